/* baud_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module baud_gen
#(
	parameter int baud_inc  = 52, // accumulator step
	parameter int acc_width = 15  // top bit is the carry, i.e. bit_tick
)
(
	input  wire        ASYNCH_CLK,
	input  wire        RTC_RESET,
	input  wire        over_sync,  // rx saw a start bit, realign phase
	output logic       bit_tick,   // one clock per carry
	output logic [1:0] over_tick   // [0] raw 16x tick, [1] tick at phase wrap
);

	localparam int over_bit = acc_width - 5; // toggles 16 times per carry

	logic [acc_width-1:0] acc;
	logic                 over_bit_q; // previous value of acc[over_bit]
	logic                 over_raw;
	logic [3:0]           phase;      // oversample position inside one bit

	// carry of the low bits lands in the top bit, top bit is dropped next clock
	always_ff @(posedge ASYNCH_CLK)
	begin
		if (RTC_RESET)
		begin
			acc        <= '0;
			over_bit_q <= 1'b0;
		end
		else
		begin
			acc        <= {1'b0, acc[acc_width-2:0]} + acc_width'(baud_inc);
			over_bit_q <= acc[over_bit];
		end
	end

	assign bit_tick = acc[acc_width-1];
	assign over_raw = over_bit_q ^ acc[over_bit]; // any edge of the tap bit

	// phase 15 marks the sampling tick, forced there on a start bit
	always_ff @(posedge ASYNCH_CLK)
	begin
		if (RTC_RESET)
			phase <= 4'h0;
		else if (over_sync)
			phase <= 4'hF; // next raw tick samples the start bit
		else if (over_raw)
			phase <= phase + 4'h1;
	end

	assign over_tick = {over_raw & (phase == 4'hF), over_raw};

	// the step is far below half the range, so a carry never repeats at once
	bit_tick_single: assert property (@(posedge ASYNCH_CLK) disable iff (RTC_RESET)
		bit_tick |=> !bit_tick);

endmodule

`default_nettype wire

/* build.f */
rtc_pkg.sv
baud_gen.sv
uart_tx.sv
uart_rx.sv
rtc_time_regs.sv
rtc_sequencer.sv
rtc_link_top.sv
tb_rtc_device.sv
tb_rtc_link.sv

/* rtc_link_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_link_top
#(
	parameter int baud_inc     = 52,   // accumulator step
	parameter int acc_width    = 15,   // accumulator width
	parameter int resp_bytes   = 33,   // status response length
	parameter int guard_cycles = 4095  // quiet time after each transaction
)
(
	input  wire                ASYNCH_CLK,
	input  wire                RTC_RESET,
	input  wire                read_status,
	input  wire                set_clock,
	input  rtc_pkg::rtc_time_u set_time,  // values for set clock
	input  wire                rxd,
	output logic               txd,
	output logic               ready,
	output rtc_pkg::rtc_time_u rtc_time   // last status read
);

	logic           bit_tick;
	logic [1:0]     over_tick;   // raw and phase-wrap oversample ticks
	logic           over_sync;
	rtc_pkg::byte_t tx_byte;
	rtc_pkg::byte_t rx_byte;
	logic           tx_enable;
	logic           tx_idle;
	logic           rx_idle;
	logic           link_ready;  // whole driver idle
	logic           store_en;
	logic [7:0]     store_index;

	assign link_ready = tx_idle & rx_idle;

	////////////////////
	// serial driver
	////////////////////

	baud_gen #(.baud_inc(baud_inc), .acc_width(acc_width)) baud_gen_i
	(
		.ASYNCH_CLK (ASYNCH_CLK),
		.RTC_RESET  (RTC_RESET),
		.over_sync  (over_sync),
		.bit_tick   (bit_tick),
		.over_tick  (over_tick)
	);

	uart_tx uart_tx_i
	(
		.ASYNCH_CLK (ASYNCH_CLK),
		.RTC_RESET  (RTC_RESET),
		.bit_tick   (bit_tick),
		.tx_enable  (tx_enable),
		.tx_byte    (tx_byte),
		.txd        (txd),
		.tx_idle    (tx_idle)
	);

	uart_rx uart_rx_i
	(
		.ASYNCH_CLK (ASYNCH_CLK),
		.RTC_RESET  (RTC_RESET),
		.over_tick  (over_tick),
		.rxd        (rxd),
		.over_sync  (over_sync),
		.rx_byte    (rx_byte),
		.rx_idle    (rx_idle)
	);

	////////////////////
	// command side
	////////////////////

	rtc_sequencer #(.resp_bytes(resp_bytes), .guard_cycles(guard_cycles)) rtc_sequencer_i
	(
		.ASYNCH_CLK  (ASYNCH_CLK),
		.RTC_RESET   (RTC_RESET),
		.read_status (read_status),
		.set_clock   (set_clock),
		.link_ready  (link_ready),
		.set_time    (set_time),
		.tx_byte     (tx_byte),
		.tx_enable   (tx_enable),
		.store_en    (store_en),
		.store_index (store_index),
		.ready       (ready)
	);

	rtc_time_regs rtc_time_regs_i
	(
		.ASYNCH_CLK  (ASYNCH_CLK),
		.RTC_RESET   (RTC_RESET),
		.store_en    (store_en),
		.store_index (store_index),
		.rx_byte     (rx_byte),
		.rtc_time    (rtc_time)
	);

endmodule

`default_nettype wire

/* rtc_pkg.sv */
`default_nettype none

package rtc_pkg;

	////////////////////
	// serial framing
	////////////////////

	typedef logic [7:0] byte_t; // one byte on the line

	// start + 8 data + stop
	// the tx and rx bit counters also rest at this value
	localparam int frame_bits = 10;

	localparam byte_t op_read  = 8'h33; // read frame, then 0x00 0x00
	localparam byte_t op_write = 8'h22; // write triple: opcode, address, value

	localparam int time_fields = 7; // second up to year

	////////////////////
	// time word
	////////////////////

	// named view, declared msb first so second lands in the low byte
	typedef struct packed
	{
		byte_t year;    // addr 6
		byte_t month;   // addr 5
		byte_t day;     // addr 4
		byte_t weekday; // addr 3
		byte_t hour;    // addr 2
		byte_t minute;  // addr 1
		byte_t second;  // addr 0
	} rtc_time_fields_t;

	// written by register address, read by field name
	typedef union packed
	{
		byte_t [time_fields-1:0] bytes;  // bytes[0] is the second
		rtc_time_fields_t        fields;
	} rtc_time_u;

	////////////////////
	// sequencer states
	////////////////////

	// read or write is kept in a separate flag, so the
	// send and response states are shared by both transactions
	typedef enum logic [2:0]
	{
		idle,       // ready high, waiting for a request
		send,       // tx_enable up until the transmitter starts
		send_count, // one cycle, step the byte counter
		send_wait,  // transmitter busy with the byte
		resp_wait,  // wait for a start bit from the chip
		resp_data,  // receiver busy
		resp_store, // byte complete, write it out
		guard       // quiet time before ready
	} seq_state_e;

endpackage

`default_nettype wire

/* rtc_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_sequencer
#(
	parameter int resp_bytes   = 33,   // bytes in the status response, >= 7
	parameter int guard_cycles = 4095  // quiet clocks after a transaction
)
(
	input  wire                ASYNCH_CLK,
	input  wire                RTC_RESET,
	input  wire                read_status,  // request level, wins over set_clock
	input  wire                set_clock,    // request level
	input  wire                link_ready,   // tx and rx both idle
	input  rtc_pkg::rtc_time_u set_time,
	output rtc_pkg::byte_t     tx_byte,
	output logic               tx_enable,
	output logic               store_en,
	output logic [7:0]         store_index,
	output logic               ready
);

	localparam int         guard_width = $clog2(guard_cycles + 1);
	localparam logic [7:0] resp_last   = 8'(resp_bytes - 1);

	rtc_pkg::seq_state_e    state;
	rtc_pkg::seq_state_e    state_next;
	logic                   is_write;   // set clock running, else read status
	logic [1:0]             sent_pos;   // sent-byte counter, byte in triple
	logic [2:0]             sent_field; // sent-byte counter, whole triples
	logic [2:0]             field_end;  // triples in this transaction
	logic                   send_done;
	logic [7:0]             resp_cnt;   // response bytes stored
	logic [guard_width-1:0] guard_cnt;

	assign field_end = is_write ? 3'(rtc_pkg::time_fields) : 3'd1; // read frame is one triple
	assign send_done = (sent_field == field_end);

	////////////////////
	// next state
	////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			rtc_pkg::idle:
				if (link_ready && (read_status || set_clock))
					state_next = rtc_pkg::send;
			rtc_pkg::send:
				if (!link_ready)
					state_next = rtc_pkg::send_count; // transmitter took the byte
			rtc_pkg::send_count:
				state_next = rtc_pkg::send_wait;
			rtc_pkg::send_wait:
				if (link_ready)
				begin
					if (!send_done)
						state_next = rtc_pkg::send;
					else if (is_write)
						state_next = rtc_pkg::guard; // nothing comes back on a write
					else
						state_next = rtc_pkg::resp_wait;
				end
			rtc_pkg::resp_wait:
				if (!link_ready)
					state_next = rtc_pkg::resp_data; // start bit seen
			rtc_pkg::resp_data:
				if (link_ready)
					state_next = rtc_pkg::resp_store;
			rtc_pkg::resp_store:
				state_next = (resp_cnt == resp_last) ? rtc_pkg::guard : rtc_pkg::resp_wait;
			rtc_pkg::guard:
				if (guard_cnt == '0)
					state_next = rtc_pkg::idle;
			default:
				state_next = rtc_pkg::idle;
		endcase
	end

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge ASYNCH_CLK)
	begin
		if (RTC_RESET)
		begin
			state      <= rtc_pkg::idle;
			ready      <= 1'b1;
			tx_enable  <= 1'b0;
			store_en   <= 1'b0;
			is_write   <= 1'b0;
			sent_pos   <= 2'd0;
			sent_field <= 3'd0;
			resp_cnt   <= 8'd0;
			guard_cnt  <= guard_width'(guard_cycles);
		end
		else
		begin
			state     <= state_next;
			ready     <= (state_next == rtc_pkg::idle);       // low from the accept clock on
			tx_enable <= (state_next == rtc_pkg::send);
			store_en  <= (state_next == rtc_pkg::resp_store);

			if (state == rtc_pkg::idle && state_next == rtc_pkg::send)
				is_write <= !read_status; // read has priority

			case (state)
				rtc_pkg::idle:
				begin
					sent_pos   <= 2'd0;
					sent_field <= 3'd0;
					resp_cnt   <= 8'd0;
				end
				rtc_pkg::send_count:
					if (sent_pos == 2'd2)
					begin
						sent_pos   <= 2'd0;
						sent_field <= sent_field + 3'd1;
					end
					else
						sent_pos <= sent_pos + 2'd1;
				rtc_pkg::resp_store:
					resp_cnt <= resp_cnt + 8'd1;
				default:
					;
			endcase

			// reloaded outside guard, counts down inside
			if (state == rtc_pkg::guard)
				guard_cnt <= guard_cnt - 1'b1;
			else
				guard_cnt <= guard_width'(guard_cycles);
		end
	end

	////////////////////
	// outgoing byte
	////////////////////

	always_comb
	begin
		case (sent_pos)
			2'd0:    tx_byte = is_write ? rtc_pkg::op_write : rtc_pkg::op_read;
			2'd1:    tx_byte = is_write ? rtc_pkg::byte_t'(sent_field) : 8'h00; // reg address
			default: tx_byte = (is_write && sent_field < 3'(rtc_pkg::time_fields)) ?
				set_time.bytes[sent_field] : 8'h00;
		endcase
	end

	assign store_index = resp_cnt; // byte number in the response

	enable_in_send: assert property (@(posedge ASYNCH_CLK) disable iff (RTC_RESET)
		tx_enable |-> (state == rtc_pkg::send));

endmodule

`default_nettype wire

/* rtc_time_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module rtc_time_regs
(
	input  wire                ASYNCH_CLK,
	input  wire                RTC_RESET,
	input  wire                store_en,     // one clock per response byte
	input  wire [7:0]          store_index,  // response byte number
	input  rtc_pkg::byte_t     rx_byte,
	output rtc_pkg::rtc_time_u rtc_time
);

	logic in_range; // byte is one of the time fields, rest is filler

	assign in_range = (store_index < 8'(rtc_pkg::time_fields));

	// response order equals register address order, second first
	always_ff @(posedge ASYNCH_CLK)
	begin
		if (RTC_RESET)
			rtc_time <= '1; // 0xFF in every field, nothing read yet
		else if (store_en && in_range)
			rtc_time.bytes[store_index] <= rx_byte;
	end

endmodule

`default_nettype wire

/* tb_rtc_device.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rtc_device
#(
	parameter int baud_inc   = 52,  // same step as the DUT accumulator
	parameter int acc_width  = 15,
	parameter int resp_bytes = 33   // bytes returned per read frame
)
(
	input  wire  ASYNCH_CLK,
	input  wire  RTC_RESET,
	input  wire  txd,  // from the DUT
	output logic rxd   // to the DUT
);

	// one bit per accumulator carry
	localparam int bit_clocks = (1 << (acc_width - 1)) / baud_inc;

	rtc_pkg::rtc_time_u image;              // chip registers by address
	rtc_pkg::byte_t     log_bytes [0:255];  // every byte seen on txd
	int                 log_count;
	int                 frame_count;        // complete triples
	int                 bad_stops;          // frames with a low stop bit

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge ASYNCH_CLK);
	endtask

	// falling edge, then sample each bit in its middle, lsb first
	task automatic get_byte(output rtc_pkg::byte_t b);
		int i;
		while (txd !== 1'b0)
			@(negedge ASYNCH_CLK);
		wait_clocks(bit_clocks / 2);
		for (i = 0; i < 8; i++)
		begin
			wait_clocks(bit_clocks);
			b[i] = txd;
		end
		wait_clocks(bit_clocks); // middle of stop
		if (txd !== 1'b1)
			bad_stops++;
		if (log_count < 256)
			log_bytes[log_count] = b;
		log_count++;
	endtask

	task automatic put_byte(input rtc_pkg::byte_t b);
		int i;
		rxd = 1'b0; // start
		wait_clocks(bit_clocks);
		for (i = 0; i < 8; i++)
		begin
			rxd = b[i];
			wait_clocks(bit_clocks);
		end
		rxd = 1'b1; // stop
		wait_clocks(bit_clocks);
	endtask

	////////////////////
	// frame decoder
	////////////////////

	initial
	begin : decode
		rtc_pkg::byte_t op;
		rtc_pkg::byte_t addr;
		rtc_pkg::byte_t value;
		int             k;
		rxd         = 1'b1;
		log_count   = 0;
		frame_count = 0;
		bad_stops   = 0;
		for (k = 0; k < rtc_pkg::time_fields; k++)
			image.bytes[k] = 8'h50 + 8'(k); // power-up contents
		@(negedge ASYNCH_CLK);
		while (RTC_RESET !== 1'b0)
			@(negedge ASYNCH_CLK);
		forever
		begin
			get_byte(op);
			get_byte(addr);
			get_byte(value);
			frame_count++;
			if (op == rtc_pkg::op_write && addr < 8'(rtc_pkg::time_fields))
				image.bytes[addr] = value;
			else if (op == rtc_pkg::op_read)
			begin
				wait_clocks(2 * bit_clocks); // turnaround, DUT goes to response wait
				// filler varies per byte so a bad store index shows up
				for (k = 0; k < resp_bytes; k++)
					put_byte((k < rtc_pkg::time_fields) ? image.bytes[k] : 8'hC0 + 8'(k));
			end
		end
	end

endmodule

`default_nettype wire

/* tb_rtc_link.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rtc_link;

	localparam int baud_inc     = 52;
	localparam int acc_width    = 15;
	localparam int resp_bytes   = 33;
	localparam int guard_cycles = 4095;
	localparam int clk_period   = 10;
	localparam int bit_clocks   = (1 << (acc_width - 1)) / baud_inc;

	// set, read, set with a held read, then three set/read pairs
	localparam int     transactions    = 9;
	localparam longint watchdog_cycles = longint'(transactions) *
		(50 * 10 * (1 << (acc_width - 1)) / baud_inc + guard_cycles) + 1000;

	logic               ASYNCH_CLK;
	logic               RTC_RESET;
	logic               read_status;
	logic               set_clock;
	rtc_pkg::rtc_time_u set_time;
	wire                rxd;
	wire                txd;
	logic               ready;
	rtc_pkg::rtc_time_u rtc_time;

	rtc_pkg::rtc_time_u last_set;  // values of the last set clock
	int                 seed = 41;
	int                 checks;
	int                 errors;
	int                 exp_frames; // triples the device should have decoded
	time                line_time = 0; // last edge on either serial line
	event               read_done;

	rtc_link_top
	#(
		.baud_inc     (baud_inc),
		.acc_width    (acc_width),
		.resp_bytes   (resp_bytes),
		.guard_cycles (guard_cycles)
	) rtc_link_top_i
	(
		.ASYNCH_CLK  (ASYNCH_CLK),
		.RTC_RESET   (RTC_RESET),
		.read_status (read_status),
		.set_clock   (set_clock),
		.set_time    (set_time),
		.rxd         (rxd),
		.txd         (txd),
		.ready       (ready),
		.rtc_time    (rtc_time)
	);

	tb_rtc_device #(.baud_inc(baud_inc), .acc_width(acc_width), .resp_bytes(resp_bytes)) device_i
	(
		.ASYNCH_CLK (ASYNCH_CLK),
		.RTC_RESET  (RTC_RESET),
		.txd        (txd),
		.rxd        (rxd)
	);

	initial
	begin
		ASYNCH_CLK = 1'b0;
		forever
			#(clk_period / 2) ASYNCH_CLK = ~ASYNCH_CLK;
	end

	// any edge on the serial pins restarts the quiet time
	always @(txd or rxd)
		line_time = $time;

	////////////////////
	// reference
	////////////////////

	// response byte k holds register address k, address 0 is the second
	function automatic rtc_pkg::rtc_time_u expected_time(input rtc_pkg::rtc_time_u applied);
		rtc_pkg::rtc_time_u e;
		e.fields.second  = applied.bytes[0];
		e.fields.minute  = applied.bytes[1];
		e.fields.hour    = applied.bytes[2];
		e.fields.weekday = applied.bytes[3];
		e.fields.day     = applied.bytes[4];
		e.fields.month   = applied.bytes[5];
		e.fields.year    = applied.bytes[6];
		return e;
	endfunction

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input rtc_pkg::byte_t got, input rtc_pkg::byte_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// field by field, printed year first
	task automatic check_time(input rtc_pkg::rtc_time_u got, input rtc_pkg::rtc_time_u exp,
		input string what);
		checks++;
		if (got.fields !== exp.fields)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h-%h-%h wd %h %h:%h:%h, expected %h-%h-%h wd %h %h:%h:%h",
				$time, what, got.fields.year, got.fields.month, got.fields.day,
				got.fields.weekday, got.fields.hour, got.fields.minute, got.fields.second,
				exp.fields.year, exp.fields.month, exp.fields.day,
				exp.fields.weekday, exp.fields.hour, exp.fields.minute, exp.fields.second);
		end
	endtask

	// compare after every completed read
	initial
	begin
		forever
		begin
			@(read_done);
			check_time(rtc_time, expected_time(last_set), "rtc_time after read status");
		end
	end

	////////////////////
	// transactions
	////////////////////

	task automatic wait_ready();
		while (ready !== 1'b1)
			@(negedge ASYNCH_CLK);
	endtask

	// new random values, request, follow to ready
	task automatic run_set(input bit hold_read);
		int start;
		int t;
		for (t = 0; t < rtc_pkg::time_fields; t++)
			set_time.bytes[t] = 8'($random(seed));
		start     = device_i.log_count;
		set_clock = 1'b1;
		@(negedge ASYNCH_CLK);
		check_bit(ready, 1'b0, "ready after set request");
		set_clock = 1'b0;
		if (hold_read)
		begin
			read_status = 1'b1; // second request during the transaction
			while (device_i.log_count < start + 21)
				@(negedge ASYNCH_CLK);
			read_status = 1'b0; // gone before guard ends
		end
		wait_ready();
		check_bit(($time - line_time) >= guard_cycles * clk_period, 1'b1,
			"quiet line before ready after set clock");
		exp_frames += rtc_pkg::time_fields;
		check_byte(8'(device_i.log_count - start), 8'd21, "bytes per set clock");
		for (t = 0; t < rtc_pkg::time_fields; t++)
		begin
			check_byte(device_i.log_bytes[start + 3 * t], rtc_pkg::op_write, "write opcode");
			check_byte(device_i.log_bytes[start + 3 * t + 1], 8'(t), "write address");
			check_byte(device_i.log_bytes[start + 3 * t + 2], set_time.bytes[t], "write value");
		end
		check_time(device_i.image, set_time, "device image");
		last_set = set_time;
	endtask

	task automatic run_read();
		int start;
		start       = device_i.log_count;
		read_status = 1'b1;
		@(negedge ASYNCH_CLK);
		check_bit(ready, 1'b0, "ready after read request");
		read_status = 1'b0;
		wait_ready();
		// whole response taken, then the guard
		check_bit(($time - line_time) >= guard_cycles * clk_period, 1'b1,
			"quiet line before ready after read status");
		exp_frames += 1;
		check_byte(8'(device_i.log_count - start), 8'd3, "bytes per read status");
		check_byte(device_i.log_bytes[start], rtc_pkg::op_read, "read opcode");
		check_byte(device_i.log_bytes[start + 1], 8'h00, "read frame byte 1");
		check_byte(device_i.log_bytes[start + 2], 8'h00, "read frame byte 2");
		-> read_done;
	endtask

	initial
	begin : stimulus
		rtc_pkg::rtc_time_u blank;
		int                 pair;
		int                 quiet_start;
		blank       = '1;
		RTC_RESET   = 1'b1;
		read_status = 1'b0;
		set_clock   = 1'b0;
		set_time    = '0;
		last_set    = '1;
		checks      = 0;
		errors      = 0;
		exp_frames  = 0;
		repeat (5) @(negedge ASYNCH_CLK);
		RTC_RESET = 1'b0;
		@(negedge ASYNCH_CLK);

		check_bit(ready, 1'b1, "ready after reset");
		check_bit(txd, 1'b1, "txd after reset");
		check_time(rtc_time, blank, "rtc_time after reset");

		run_set(1'b0);
		run_read();

		// held read during a set, nothing may follow
		run_set(1'b1);
		quiet_start = device_i.log_count;
		repeat (30 * bit_clocks) @(negedge ASYNCH_CLK);
		check_bit(ready, 1'b1, "ready after held request");
		check_byte(8'(device_i.log_count - quiet_start), 8'd0, "bytes after held request");

		for (pair = 0; pair < 3; pair++)
		begin
			run_set(1'b0);
			run_read();
		end

		@(negedge ASYNCH_CLK);
		check_byte(8'(device_i.frame_count), 8'(exp_frames), "frames decoded by device");
		check_bit(device_i.bad_stops == 0, 1'b1, "stop bits seen by device");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// worst case frame count per transaction plus guard
	initial
	begin
		repeat (watchdog_cycles) @(posedge ASYNCH_CLK);
		$display("timed out after %0d clocks, a transaction never finished", watchdog_cycles);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx
(
	input  wire            ASYNCH_CLK,
	input  wire            RTC_RESET,
	input  wire [1:0]      over_tick,  // [0] raw 16x, [1] at phase wrap
	input  wire            rxd,
	output logic           over_sync,  // one clock at start detection
	output rtc_pkg::byte_t rx_byte,
	output logic           rx_idle
);

	localparam logic [3:0] cnt_idle = 4'(rtc_pkg::frame_bits);

	logic [7:0] samples;   // last eight line samples, [0] newest
	logic [3:0] bit_cnt;   // frame bit to sample next, idle at frame_bits
	logic       start_det; // eight low samples in a row while idle
	logic       data_bit;  // bit_cnt points at one of the 8 data bits

	////////////////////
	// line sampling
	////////////////////

	always_ff @(posedge ASYNCH_CLK)
	begin
		if (RTC_RESET)
			samples <= 8'hFF; // line idles high
		else if (over_tick[0])
			samples <= {samples[6:0], rxd};
	end

	assign rx_idle   = (bit_cnt == cnt_idle);
	assign start_det = rx_idle && (samples == 8'h00);

	////////////////////
	// frame counter
	////////////////////

	always_ff @(posedge ASYNCH_CLK)
	begin
		if (RTC_RESET)
		begin
			bit_cnt   <= cnt_idle;
			over_sync <= 1'b0;
		end
		else
		begin
			over_sync <= start_det; // phase goes to 15, next tick samples start
			if (start_det)
				bit_cnt <= 4'd0;
			else if (!rx_idle && over_tick[1])
				bit_cnt <= bit_cnt + 4'd1; // stop bit sample ends the frame
		end
	end

	// bits 1..8, start and stop are only counted
	assign data_bit = (bit_cnt != 4'd0) && (bit_cnt < 4'd9);

	// lsb arrives first, shift in from the top
	always_ff @(posedge ASYNCH_CLK)
	begin
		if (over_tick[1] && data_bit)
			rx_byte <= {samples[0], rx_byte[7:1]};
	end

	// frame from the chip closes with a high stop bit
	stop_bit_high: assert property (@(posedge ASYNCH_CLK) disable iff (RTC_RESET)
		over_tick[1] && (bit_cnt == 4'd9) |-> samples[0]);

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx
(
	input  wire            ASYNCH_CLK,
	input  wire            RTC_RESET,
	input  wire            bit_tick,
	input  wire            tx_enable,  // level, sampled on bit_tick while idle
	input  rtc_pkg::byte_t tx_byte,
	output logic           txd,
	output logic           tx_idle
);

	localparam logic [3:0] cnt_idle = 4'(rtc_pkg::frame_bits);

	logic [3:0]                     bit_cnt;  // bit on the line, idle at frame_bits
	logic [rtc_pkg::frame_bits-1:0] frame_q;  // stop, data msb..lsb, start

	////////////////////
	// bit counter
	////////////////////

	always_ff @(posedge ASYNCH_CLK)
	begin
		if (RTC_RESET)
			bit_cnt <= cnt_idle;
		else if (!tx_idle && bit_tick)
			bit_cnt <= bit_cnt + 4'd1; // next bit, stop bit returns to idle
		else if (tx_enable && bit_tick)
			bit_cnt <= 4'd0; // start bit goes out now
	end

	assign tx_idle = (bit_cnt == cnt_idle);

	// frame follows tx_byte until the start, then holds
	always_ff @(posedge ASYNCH_CLK)
	begin
		if (tx_idle)
			frame_q <= {1'b1, tx_byte, 1'b0};
	end

	////////////////////
	// line
	////////////////////

	assign txd = tx_idle ? 1'b1 : frame_q[bit_cnt]; // lsb first after start

	idle_line_high: assert property (@(posedge ASYNCH_CLK) disable iff (RTC_RESET)
		tx_idle |-> txd);

endmodule

`default_nettype wire
